// ==== design/raster_pkg.sv ====
`default_nettype none

package raster_pkg;

    // fixed point format, signed Q16.16
    localparam int WORD_WIDTH = 32;
    localparam int FRAC_BITS = 16;

    localparam int SCR_WIDTH = 320;
    localparam int SCR_HEIGHT = 240;
    localparam int SC_WIDTH = $clog2(SCR_WIDTH > SCR_HEIGHT ? SCR_WIDTH : SCR_HEIGHT);

    localparam int FX_ONE = 1 << FRAC_BITS;

    // one load cycle plus one step per bit of the 33-bit dividend 2^32
    localparam int RECIP_CYCLES = WORD_WIDTH + 2;

    typedef logic signed [WORD_WIDTH-1:0] word_t;

    typedef struct packed {
        word_t x;
        word_t y;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    typedef struct packed {
        logic [SC_WIDTH-1:0] x;
        logic [SC_WIDTH-1:0] y;
        logic                last;
    } pos_t;

    typedef struct packed {
        logic [SC_WIDTH-1:0] x;
        logic [SC_WIDTH-1:0] y;
        logic                last;
        word_t               l0;
        word_t               l1;
        word_t               l2;
    } frag_t;

    // Q16.16 product, rounded towards minus infinity
    function automatic word_t fx_mul(input word_t a, input word_t b);
        logic signed [2*WORD_WIDTH-1:0] prod;
        prod = a * b;
        prod = prod >>> FRAC_BITS;
        return prod[WORD_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== design/fixed_recip.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_recip
    import raster_pkg::*;
(
    input  wire   clk_i,
    input  wire   nrst_i,
    input  wire   start_i,
    input  wire   word_t den_i,
    output logic  done_o,
    output word_t q_o
);

    logic [$clog2(RECIP_CYCLES)-1:0] cnt;
    logic busy;

    logic [WORD_WIDTH-1:0] dmag;    // divisor magnitude
    logic [WORD_WIDTH-1:0] rem;
    logic [WORD_WIDTH-1:0] quo;
    logic [WORD_WIDTH:0]   num;     // dividend bits left, msb first
    logic neg;
    logic zero;

    logic [WORD_WIDTH:0] trial;
    logic fits;

    assign trial = {rem, num[WORD_WIDTH]};
    assign fits = trial >= {1'b0, dmag};

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            busy <= 1'b0;
            cnt <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy <= 1'b1;
                cnt <= $bits(cnt)'(RECIP_CYCLES - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == 1) begin // final step lands on this edge
                    busy <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            dmag <= den_i[WORD_WIDTH-1] ? -den_i : den_i;
            neg <= den_i[WORD_WIDTH-1];
            zero <= den_i == '0;
            rem <= '0;
            quo <= '0;
            num <= {1'b1, {WORD_WIDTH{1'b0}}};  // 2^32, i.e. 1.0 squared
        end else if (busy) begin
            // remainder stays below dmag so it fits one word
            rem <= WORD_WIDTH'(fits ? trial - {1'b0, dmag} : trial);
            quo <= {quo[WORD_WIDTH-2:0], fits};
            num <= num << 1;
        end
    end

    // quotient overflow above bit 31 is dropped, matching a truncated word
    assign q_o = zero ? '0 : (neg ? -quo : quo);

endmodule

`default_nettype wire

// ==== design/pixel_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner
    import raster_pkg::*;
(
    input  wire   clk_i,
    input  wire   nrst_i,
    input  wire   start_i,
    input  wire   tri_t tri_i,
    output logic  pos_valid_o,
    output pos_t  pos_o,
    input  wire   pos_ready_i
);

    logic [SC_WIDTH-1:0] box_x_min, box_x_max, box_y_min, box_y_max;
    logic [SC_WIDTH-1:0] x_min, x_max, y_max;
    logic [SC_WIDTH-1:0] x_cur, y_cur;
    logic at_x_end;
    logic at_y_end;

    function automatic word_t min3(input word_t a, input word_t b, input word_t c);
        word_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic word_t max3(input word_t a, input word_t b, input word_t c);
        word_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // integer part, clamped into [0, limit - 1]
    function automatic logic [SC_WIDTH-1:0] to_screen(input word_t v, input int limit);
        word_t ip;
        ip = v >>> FRAC_BITS;
        if (ip < 0)
            return '0;
        if (ip > limit - 1)
            return SC_WIDTH'(limit - 1);
        return ip[SC_WIDTH-1:0];
    endfunction

    assign box_x_min = to_screen(min3(tri_i.v0.x, tri_i.v1.x, tri_i.v2.x), SCR_WIDTH);
    assign box_x_max = to_screen(max3(tri_i.v0.x, tri_i.v1.x, tri_i.v2.x), SCR_WIDTH);
    assign box_y_min = to_screen(min3(tri_i.v0.y, tri_i.v1.y, tri_i.v2.y), SCR_HEIGHT);
    assign box_y_max = to_screen(max3(tri_i.v0.y, tri_i.v1.y, tri_i.v2.y), SCR_HEIGHT);

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            x_min <= box_x_min;
            x_max <= box_x_max;
            y_max <= box_y_max;
        end
    end

    assign at_x_end = x_cur == x_max;
    assign at_y_end = y_cur == y_max;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            pos_valid_o <= 1'b0;
            x_cur <= '0;
            y_cur <= '0;
        end else if (start_i) begin
            pos_valid_o <= 1'b1;
            x_cur <= box_x_min;
            y_cur <= box_y_min;
        end else if (pos_valid_o && pos_ready_i) begin
            if (at_x_end) begin
                x_cur <= x_min;
                if (at_y_end)
                    pos_valid_o <= 1'b0;   // bottom-right pixel gone
                else
                    y_cur <= y_cur + 1'b1;
            end else begin
                x_cur <= x_cur + 1'b1;
            end
        end
    end

    assign pos_o = '{x: x_cur, y: y_cur, last: at_x_end && at_y_end};

endmodule

`default_nettype wire

// ==== design/bary_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module bary_pipe
    import raster_pkg::*;
(
    input  wire   clk_i,
    input  wire   nrst_i,
    input  wire   run_i,
    input  wire   tri_t tri_i,
    output logic  init_o,
    output logic  discard_o,
    output logic  busy_o,
    output logic  recip_start_o,
    output word_t recip_den_o,
    input  wire   recip_done_i,
    input  wire   word_t recip_q_i,
    output logic  scan_start_o,
    output tri_t  scan_tri_o,
    input  wire   pos_valid_i,
    input  wire   pos_t pos_i,
    output logic  pos_ready_o,
    output logic  frag_valid_o,
    output frag_t frag_o,
    input  wire   frag_ready_i
);

    typedef enum logic [4:0] {
        S_IDLE, S_SETUP1, S_SETUP2, S_SETUP3, S_SETUP4, S_SETUP5, S_SETUP6, S_SETUP7,
        S_SETUP8, S_RECIP, S_INIT, S_AWAIT_POS, S_RUN1, S_RUN2, S_RUN3, S_RUN4,
        S_RUN5, S_RUN6, S_RUN7, S_RUN8, S_FRAG, S_DONE
    } state_t;

    state_t state;

    tri_t tri_q;
    pos_t pix;

    // edge terms and setup partials
    word_t dy12, dx21, dx02, dy20, ny20, dx10;
    word_t sy10, sy21, sy02;
    word_t det, area, inv;

    // per pixel
    word_t ta, tb, sum, p0, p1;
    word_t w0, w1, w2;

    // shared arithmetic units
    word_t add_a, add_b, add_y;
    word_t sub_a, sub_b, sub_y;
    word_t mul_a, mul_b, mul_y;

    assign add_y = add_a + add_b;
    assign sub_y = sub_a - sub_b;
    assign mul_y = fx_mul(mul_a, mul_b);

    always_comb begin
        add_a = '0;
        add_b = '0;
        sub_a = '0;
        sub_b = '0;
        mul_a = '0;
        mul_b = '0;
        case (state)
            S_SETUP1: begin
                sub_a = tri_q.v1.y;  sub_b = tri_q.v2.y;
                add_a = tri_q.v1.y;  add_b = tri_q.v0.y;
            end
            S_SETUP2: begin
                sub_a = tri_q.v0.x;  sub_b = tri_q.v2.x;
                add_a = tri_q.v2.y;  add_b = tri_q.v1.y;
            end
            S_SETUP3: begin
                sub_a = tri_q.v2.x;  sub_b = tri_q.v1.x;
                add_a = tri_q.v0.y;  add_b = tri_q.v2.y;
                mul_a = dy12;        mul_b = dx02;      // first det product
            end
            S_SETUP4: begin
                sub_a = tri_q.v0.y;  sub_b = tri_q.v2.y;
                mul_a = dx02;        mul_b = sy02;      // area, edge 2 to 0
            end
            S_SETUP5: begin
                sub_a = tri_q.v1.x;  sub_b = tri_q.v0.x;
                mul_a = dx21;        mul_b = ny20;
            end
            S_SETUP6: begin
                sub_a = tri_q.v2.y;  sub_b = tri_q.v0.y;
                mul_a = dx21;        mul_b = sy21;
                add_a = det;         add_b = p0;
            end
            S_SETUP7: begin
                mul_a = dx10;        mul_b = sy10;
                add_a = area;        add_b = p1;
            end
            S_SETUP8: begin
                add_a = area;        add_b = p0;
            end
            S_AWAIT_POS: begin
                sub_a = word_t'(pos_i.x) << FRAC_BITS;
                sub_b = tri_q.v2.x;
            end
            S_RUN1: begin
                sub_a = word_t'(pix.y) << FRAC_BITS;
                sub_b = tri_q.v2.y;
                mul_a = dy12;        mul_b = ta;
            end
            S_RUN2: begin
                mul_a = dx21;        mul_b = tb;
            end
            S_RUN3: begin
                add_a = p0;          add_b = p1;
                mul_a = dy20;        mul_b = ta;
            end
            S_RUN4: begin
                mul_a = sum;         mul_b = inv;
            end
            S_RUN5: begin
                mul_a = dx02;        mul_b = tb;
                sub_a = FX_ONE;      sub_b = w0;
            end
            S_RUN6: begin
                add_a = p0;          add_b = p1;
            end
            S_RUN7: begin
                mul_a = sum;         mul_b = inv;
            end
            S_RUN8: begin
                sub_a = w2;          sub_b = w1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        case (state)
            S_IDLE:   if (run_i) tri_q <= tri_i;
            S_SETUP1: begin dy12 <= sub_y; sy10 <= add_y; end
            S_SETUP2: begin dx02 <= sub_y; sy21 <= add_y; end
            S_SETUP3: begin dx21 <= sub_y; sy02 <= add_y; det <= mul_y; end
            S_SETUP4: begin ny20 <= sub_y; area <= mul_y; end
            S_SETUP5: begin dx10 <= sub_y; p0 <= mul_y; end
            S_SETUP6: begin dy20 <= sub_y; p1 <= mul_y; det <= add_y; end
            S_SETUP7: begin p0 <= mul_y; area <= add_y; end
            S_SETUP8: area <= add_y;
            S_RECIP:  if (recip_done_i) inv <= recip_q_i;
            S_AWAIT_POS: begin
                if (pos_valid_i) begin
                    pix <= pos_i;
                    ta <= sub_y;
                end
            end
            S_RUN1: begin tb <= sub_y; p0 <= mul_y; end
            S_RUN2: p1 <= mul_y;
            S_RUN3: begin sum <= add_y; p0 <= mul_y; end
            S_RUN4: w0 <= mul_y;
            S_RUN5: begin p1 <= mul_y; w2 <= sub_y; end
            S_RUN6: sum <= add_y;
            S_RUN7: w1 <= mul_y;
            S_RUN8: w2 <= sub_y;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:      if (run_i) state <= S_SETUP1;
                S_SETUP1:    state <= S_SETUP2;
                S_SETUP2:    state <= S_SETUP3;
                S_SETUP3:    state <= S_SETUP4;
                S_SETUP4:    state <= S_SETUP5;
                S_SETUP5:    state <= S_SETUP6;
                S_SETUP6:    state <= S_SETUP7;
                S_SETUP7:    state <= S_SETUP8;
                S_SETUP8:    state <= S_RECIP;
                S_RECIP:     if (recip_done_i) state <= S_INIT;
                S_INIT:      state <= (area < 0) ? S_AWAIT_POS : S_IDLE;
                S_AWAIT_POS: if (pos_valid_i) state <= S_RUN1;
                S_RUN1:      state <= S_RUN2;
                S_RUN2:      state <= S_RUN3;
                S_RUN3:      state <= S_RUN4;
                S_RUN4:      state <= S_RUN5;
                S_RUN5:      state <= S_RUN6;
                S_RUN6:      state <= S_RUN7;
                S_RUN7:      state <= S_RUN8;
                S_RUN8:      state <= S_FRAG;
                S_FRAG: begin
                    if (frag_ready_i)
                        state <= pix.last ? S_DONE : S_AWAIT_POS;
                end
                S_DONE:      if (!run_i) state <= S_IDLE;  // wait for run to drop
                default:     state <= S_IDLE;
            endcase
        end
    end

    assign busy_o = (state != S_IDLE) && (state != S_DONE);
    assign init_o = state == S_INIT;
    assign discard_o = init_o && !(area < 0);    // back-facing or degenerate
    assign scan_start_o = init_o && (area < 0);
    assign scan_tri_o = tri_q;

    assign recip_start_o = state == S_SETUP8;    // det settled in setup 6
    assign recip_den_o = det;

    assign pos_ready_o = state == S_AWAIT_POS;

    assign frag_valid_o = state == S_FRAG;
    assign frag_o = '{x: pix.x, y: pix.y, last: pix.last, l0: w0, l1: w1, l2: w2};

endmodule

`default_nettype wire

// ==== design/raster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_top
    import raster_pkg::*;
(
    input  wire   clk_i,
    input  wire   nrst_i,
    input  wire   run_i,
    input  wire   tri_t tri_i,
    input  wire   frag_ready_i,
    output logic  init_o,
    output logic  discard_o,
    output logic  busy_o,
    output logic  frag_valid_o,
    output frag_t frag_o
);

    logic  recip_start;
    logic  recip_done;
    word_t recip_den;
    word_t recip_q;

    logic scan_start;
    tri_t scan_tri;

    // position stream, scanner to pipe
    logic pos_valid;
    logic pos_ready;
    pos_t pos;

    bary_pipe bary_pipe_inst (
        .clk_i         (clk_i),
        .nrst_i        (nrst_i),
        .run_i         (run_i),
        .tri_i         (tri_i),
        .init_o        (init_o),
        .discard_o     (discard_o),
        .busy_o        (busy_o),
        .recip_start_o (recip_start),
        .recip_den_o   (recip_den),
        .recip_done_i  (recip_done),
        .recip_q_i     (recip_q),
        .scan_start_o  (scan_start),
        .scan_tri_o    (scan_tri),
        .pos_valid_i   (pos_valid),
        .pos_i         (pos),
        .pos_ready_o   (pos_ready),
        .frag_valid_o  (frag_valid_o),
        .frag_o        (frag_o),
        .frag_ready_i  (frag_ready_i)
    );

    fixed_recip fixed_recip_inst (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .start_i (recip_start),
        .den_i   (recip_den),
        .done_o  (recip_done),
        .q_o     (recip_q)
    );

    pixel_scanner pixel_scanner_inst (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .start_i     (scan_start),
        .tri_i       (scan_tri),
        .pos_valid_o (pos_valid),
        .pos_o       (pos),
        .pos_ready_i (pos_ready)
    );

endmodule

`default_nettype wire

// ==== verif/raster_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_checker
    import raster_pkg::*;
(
    input  wire   clk_i,
    input  wire   nrst_i,
    input  wire   init_i,
    input  wire   discard_i,
    input  wire   frag_valid_i,
    input  wire   frag_ready_i,
    input  wire   frag_t frag_i,
    input  wire   pos_valid_i,
    input  wire   pos_ready_i,
    input  wire   pos_t pos_i
);

    frag_hold: assert property (@(posedge clk_i) disable iff (!nrst_i)
        (frag_valid_i && !frag_ready_i) |=> (frag_valid_i && $stable(frag_i)))
        else $error("fragment stream changed while stalled");

    // scanner holds its position until the pipe takes it
    pos_hold: assert property (@(posedge clk_i) disable iff (!nrst_i)
        (pos_valid_i && !pos_ready_i) |=> (pos_valid_i && $stable(pos_i)))
        else $error("position stream changed while stalled");

    // a culled triangle never starts the scanner
    discard_in_init: assert property (@(posedge clk_i) disable iff (!nrst_i)
        discard_i |-> init_i ##1 !pos_valid_i)
        else $error("discard outside the init cycle or followed by a position");

    init_single: assert property (@(posedge clk_i) disable iff (!nrst_i)
        init_i |=> !init_i)
        else $error("init held for two cycles");

endmodule

bind raster_top raster_checker raster_checker_inst (
    .clk_i        (clk_i),
    .nrst_i       (nrst_i),
    .init_i       (init_o),
    .discard_i    (discard_o),
    .frag_valid_i (frag_valid_o),
    .frag_ready_i (frag_ready_i),
    .frag_i       (frag_o),
    .pos_valid_i  (pos_valid),
    .pos_ready_i  (pos_ready),
    .pos_i        (pos)
);

`default_nettype wire

// ==== verif/raster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_tb
    import raster_pkg::*;
();

    logic  clk;
    logic  nrst;
    logic  run;
    tri_t  tri_in;
    logic  frag_ready;
    logic  init;
    logic  discard;
    logic  busy;
    logic  frag_valid;
    frag_t frag;

    integer seed;
    int errors;
    int checks;
    word_t model_area;
    frag_t exp_q[$];
    frag_t got_q[$];

    raster_top raster_top_inst (
        .clk_i        (clk),
        .nrst_i       (nrst),
        .run_i        (run),
        .tri_i        (tri_in),
        .frag_ready_i (frag_ready),
        .init_o       (init),
        .discard_o    (discard),
        .busy_o       (busy),
        .frag_valid_o (frag_valid),
        .frag_o       (frag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // floor of the full 64-bit product
    function automatic word_t qmul(input word_t a, input word_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return word_t'(p >>> FRAC_BITS);
    endfunction

    function automatic word_t recip_model(input word_t d);
        if (d == 0)
            return '0;
        return word_t'((longint'(1) << 32) / longint'(d));   // truncates toward zero
    endfunction

    // integer part of the min or max coordinate clamped to the screen
    function automatic int box_edge(input word_t a, input word_t b, input word_t c,
                                    input bit upper, input int limit);
        int e;
        int fb;
        int fc;
        e = a >>> FRAC_BITS;
        fb = b >>> FRAC_BITS;
        fc = c >>> FRAC_BITS;
        if (upper ? fb > e : fb < e)
            e = fb;
        if (upper ? fc > e : fc < e)
            e = fc;
        if (e < 0)
            e = 0;
        if (e > limit - 1)
            e = limit - 1;
        return e;
    endfunction

    task automatic build_expected(input tri_t t);
        word_t dy12, dx21, dx02, dy20, det, inv, ta, tb, l0, l1;
        int xmin, xmax, ymin, ymax;
        frag_t f;
        dy12 = t.v1.y - t.v2.y;
        dx21 = t.v2.x - t.v1.x;
        dx02 = t.v0.x - t.v2.x;
        dy20 = t.v2.y - t.v0.y;
        det = qmul(dy12, dx02) + qmul(dx21, t.v0.y - t.v2.y);
        model_area = qmul(t.v1.x - t.v0.x, t.v1.y + t.v0.y)
                   + qmul(t.v2.x - t.v1.x, t.v2.y + t.v1.y)
                   + qmul(t.v0.x - t.v2.x, t.v0.y + t.v2.y);   // shoelace
        inv = recip_model(det);
        xmin = box_edge(t.v0.x, t.v1.x, t.v2.x, 1'b0, SCR_WIDTH);
        xmax = box_edge(t.v0.x, t.v1.x, t.v2.x, 1'b1, SCR_WIDTH);
        ymin = box_edge(t.v0.y, t.v1.y, t.v2.y, 1'b0, SCR_HEIGHT);
        ymax = box_edge(t.v0.y, t.v1.y, t.v2.y, 1'b1, SCR_HEIGHT);
        exp_q.delete();
        for (int y = ymin; y <= ymax; y++) begin
            for (int x = xmin; x <= xmax; x++) begin
                ta = (word_t'(x) << FRAC_BITS) - t.v2.x;
                tb = (word_t'(y) << FRAC_BITS) - t.v2.y;
                l0 = qmul(qmul(dy12, ta) + qmul(dx21, tb), inv);
                l1 = qmul(qmul(dy20, ta) + qmul(dx02, tb), inv);
                f.x = SC_WIDTH'(x);
                f.y = SC_WIDTH'(y);
                f.last = (x == xmax) && (y == ymax);
                f.l0 = l0;
                f.l1 = l1;
                f.l2 = word_t'(1 << FRAC_BITS) - l0 - l1;
                exp_q.push_back(f);
            end
        end
    endtask

    // independent vertices in a 16 pixel square give a random winding
    task automatic rand_tri(output tri_t t);
        int bx;
        int by;
        vertex_t v[3];
        bx = ($random(seed) & 32'h7fff_ffff) % (SCR_WIDTH - 17);
        by = ($random(seed) & 32'h7fff_ffff) % (SCR_HEIGHT - 17);
        for (int i = 0; i < 3; i++) begin
            v[i].x = word_t'(((bx + ($random(seed) & 15)) << FRAC_BITS)
                             + ($random(seed) & 65535));
            v[i].y = word_t'(((by + ($random(seed) & 15)) << FRAC_BITS)
                             + ($random(seed) & 65535));
        end
        t.v0 = v[0];
        t.v1 = v[1];
        t.v2 = v[2];
    endtask

    task automatic pick_tri(input bit keep, output tri_t t);
        bit found;
        found = 1'b0;
        for (int i = 0; i < 100 && !found; i++) begin
            rand_tri(t);
            build_expected(t);
            found = (model_area < 0) == keep;
        end
        if (!found) begin
            errors++;
            $display("could not generate a %s triangle", keep ? "kept" : "culled");
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        checks++;
        if (init !== 1'b0 || discard !== 1'b0 || busy !== 1'b0 || frag_valid !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: %s init %b discard %b busy %b frag_valid %b, not low",
                     $time, phase, init, discard, busy, frag_valid);
        end
    endtask

    // runs one job up to the last fragment or the discard and fills got_q
    task automatic run_job(input tri_t t, input bit stall, input bit hold_run, output bit ok);
        int wait_cnt;
        int total_cnt;
        bit keep;
        bit done;
        ok = 1'b0;
        build_expected(t);
        keep = model_area < 0;
        got_q.delete();
        run = 1'b0;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (busy && wait_cnt < 5000);
        if (busy) begin
            errors++;
            $display("timeout: pipe never returned to idle before a new run");
            return;
        end
        @(negedge clk);                   // lets a done pipe fall back to idle
        tri_in = t;
        run = 1'b1;
        @(negedge clk);
        if (!hold_run)
            run = 1'b0;
        wait_cnt = 0;
        while (!init && wait_cnt < 200) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!init) begin
            errors++;
            $display("timeout: no init pulse after run");
            return;
        end
        checks++;
        if (discard !== !keep) begin
            errors++;
            $display("mismatch at %0t: discard=%b, model area %h", $time, discard, model_area);
            return;
        end
        if (!keep) begin
            wait_cnt = 0;
            while (busy && wait_cnt < 20) begin
                @(negedge clk);
                wait_cnt++;
                checks++;
                if (frag_valid) begin
                    errors++;
                    $display("mismatch at %0t: fragment after a discard", $time);
                end
            end
            if (busy) begin
                errors++;
                $display("timeout: busy stayed high after a discard");
                return;
            end
            ok = 1'b1;
            return;
        end
        done = 1'b0;
        wait_cnt = 0;
        total_cnt = 0;
        while (!done) begin
            @(negedge clk);
            total_cnt++;
            frag_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
            if (frag_valid && frag_ready) begin
                got_q.push_back(frag);
                done = frag.last;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
            end
            if (!done && (wait_cnt > 200 || total_cnt > 20000)) begin
                errors++;
                frag_ready = 1'b1;
                $display("timeout: no last fragment after %0d received", got_q.size());
                return;
            end
        end
        frag_ready = 1'b1;
        @(negedge clk);
        checks++;
        if (busy) begin
            errors++;
            $display("mismatch at %0t: busy still high after the last fragment", $time);
        end
        ok = 1'b1;
    endtask

    task automatic compare_frags(input bit with_weights);
        frag_t e;
        frag_t g;
        checks++;
        if (got_q.size() != exp_q.size()) begin
            errors++;
            $display("mismatch at %0t: %0d fragments, expected %0d",
                     $time, got_q.size(), exp_q.size());
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            e = exp_q[i];
            g = got_q[i];
            checks++;
            if (g.x !== e.x || g.y !== e.y || g.last !== e.last) begin
                errors++;
                $display("mismatch at %0t: fragment %0d (%0d,%0d,%b), expected (%0d,%0d,%b)",
                         $time, i, g.x, g.y, g.last, e.x, e.y, e.last);
            end else if (with_weights && (g.l0 !== e.l0 || g.l1 !== e.l1 || g.l2 !== e.l2)) begin
                errors++;
                $display("mismatch at %0t: fragment %0d weights %h %h %h, expected %h %h %h",
                         $time, i, g.l0, g.l1, g.l2, e.l0, e.l1, e.l2);
            end
        end
    endtask

    initial begin
        tri_t t;
        bit ok;
        int mark;
        frag_t ref_q[$];
        seed = 32'hf88a;
        errors = 0;
        checks = 0;
        nrst = 1'b0;
        run = 1'b0;
        tri_in = '0;
        frag_ready = 1'b1;

        mark = errors;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs("in reset");
        end
        nrst = 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");
        $display("test 1 reset state: %0d errors", errors - mark);

        mark = errors;
        for (int i = 0; i < 4; i++) begin
            pick_tri(1'b0, t);
            run_job(t, 1'b0, 1'b0, ok);
        end
        $display("test 2 culling: %0d errors", errors - mark);

        mark = errors;
        for (int i = 0; i < 4; i++) begin
            pick_tri(1'b1, t);
            run_job(t, 1'b0, 1'b0, ok);
            if (ok)
                compare_frags(1'b0);
        end
        $display("test 3 coverage and order: %0d errors", errors - mark);

        mark = errors;
        for (int i = 0; i < 4; i++) begin
            pick_tri(1'b1, t);
            run_job(t, 1'b0, 1'b0, ok);
            if (ok)
                compare_frags(1'b1);
        end
        $display("test 4 weights: %0d errors", errors - mark);

        mark = errors;
        for (int i = 0; i < 3; i++) begin
            pick_tri(1'b1, t);
            run_job(t, 1'b0, 1'b0, ok);
            ref_q = got_q;
            run_job(t, 1'b1, 1'b0, ok);
            checks++;
            if (got_q.size() != ref_q.size()) begin
                errors++;
                $display("mismatch at %0t: %0d stalled fragments, %0d without stalls",
                         $time, got_q.size(), ref_q.size());
            end
            for (int j = 0; j < got_q.size() && j < ref_q.size(); j++) begin
                if (got_q[j] !== ref_q[j]) begin
                    errors++;
                    $display("mismatch at %0t: stalled fragment %0d differs", $time, j);
                end
            end
            if (ok)
                compare_frags(1'b1);
        end
        $display("test 5 back-pressure: %0d errors", errors - mark);

        mark = errors;
        pick_tri(1'b1, t);
        run_job(t, 1'b0, 1'b1, ok);
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (busy || init) begin
                errors++;
                $display("pipe restarted while run_i stayed high after the last fragment");
            end
        end
        pick_tri(1'b1, t);
        run_job(t, 1'b0, 1'b0, ok);       // drops run_i and raises it again
        if (ok)
            compare_frags(1'b1);
        $display("test 6 run handshake: %0d errors", errors - mark);

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/raster_pkg.sv
design/fixed_recip.sv
design/pixel_scanner.sv
design/bary_pipe.sv
design/raster_top.sv
verif/raster_checker.sv
verif/raster_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module raster_tb -Mdir obj_dir
	./obj_dir/Vraster_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
